// File: sim.f
logic/display_pkg.sv
logic/play_pkg.sv
logic/scroll_timer.sv
logic/object_track.sv
logic/player_referee.sv
logic/tile_writer.sv
logic/game_engine.sv
verif/game_engine_sva.sv
verif/tb_game_engine.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the game engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_game_engine \
    -f sim.f -o tb_game_engine
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed"
    exit $status
fi

./obj_dir/tb_game_engine
status=$?
if [ $status -ne 0 ]; then
    echo "simulation reported failure"
    exit $status
fi

echo "simulation finished cleanly"
exit 0

// File: verif/tb_game_engine.sv
`timescale 1ns/1ps
`default_nettype none

module tb_game_engine;
    import play_pkg::*;
    import display_pkg::*;

    localparam int idle_cycles  = 20;
    localparam int coin_cycles  = 2200000;  // long enough for every speed-up
    localparam int mixed_cycles = 300000;
    localparam int fall_cycles  = 200;
    localparam longint watchdog_ns =
        longint'(idle_cycles + coin_cycles + mixed_cycles + fall_cycles + 10) * 10 + 1000;

    // object tracks in the order coin, ghost, life, cliff
    localparam logic [3:0][7:0] track_seed  = {8'hb5, 8'h2e, 8'ha6, 8'h69};
    localparam logic [3:0][7:0] track_base  = {8'd50, 8'd90, 8'd50, 8'd34};
    localparam logic [3:0][7:0] track_span  = {8'd101, 8'd5, 8'd5, 8'd6};
    localparam logic [3:0][7:0] track_start = {8'd20, 8'd37, 8'd37, 8'd38};

    logic                            clk = 1'b0;
    logic                            reset;
    logic                            game_on;
    player_pos_t [player_count-1:0]  players;
    offset_t                         bg_x_offset;
    object_cols_t                    cols;
    score_t                          score;
    logic [player_count-1:0]         dead;
    logic [player_count-1:0]         on_ground;
    logic                            game_over;
    tile_write_t                     tile_wr;

    logic [31:0] rng;

    // reference model state as the DUT should show it after the next edge
    delay_t                  m_cnt;
    delay_t                  m_delay;
    offset_t                 m_offset;
    score_t                  m_score;
    logic [player_count-1:0] m_dead;
    logic [player_count-1:0] m_ground;
    logic                    m_over;
    logic                    m_coin_eaten;
    logic                    m_life_eaten;
    int                      m_slot;
    int                      m_anim;
    tile_write_t             m_wr;
    logic [7:0]              m_lfsr [4];
    col_t                    m_col [4];
    logic [1:0]              m_pick;

    game_engine DUT (
        .clk(clk), .reset(reset), .game_on(game_on), .players(players),
        .bg_x_offset(bg_x_offset), .cols(cols), .score(score), .dead(dead),
        .on_ground(on_ground), .game_over(game_over), .tile_wr(tile_wr)
    );

    always #5 clk = ~clk;

    // 32-bit fibonacci lfsr on taps 32 22 2 1
    function automatic int random_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            rng = {rng[30:0], rng[31] ^ rng[21] ^ rng[1] ^ rng[0]};
            v = (v << 1) | int'(rng[0]);
        end
        return v;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_score(input score_t got, input score_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at %0t: score expected %0d got %0d", $time, exp, got));
        end
    endtask

    task automatic check_offset(input offset_t got, input offset_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at %0t: bg_x_offset expected %0d got %0d",
                $time, exp, got));
        end
    endtask

    task automatic check_flags(input string name, input logic [player_count-1:0] got,
                               input logic [player_count-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at %0t: %s expected %b got %b", $time, name, exp, got));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at %0t: %s expected %b got %b", $time, name, exp, got));
        end
    endtask

    task automatic check_cols(input object_cols_t got, input object_cols_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at %0t: cols expected %h got %h", $time, exp, got));
        end
    endtask

    // fields of an unstrobed write carry no meaning
    task automatic check_write(input tile_write_t got, input tile_write_t exp);
        if ((exp.strobe && got !== exp) || (!exp.strobe && got.strobe !== 1'b0)) begin
            abort_run($sformatf("Mismatch at %0t: tile_wr expected %h got %h", $time, exp, got));
        end
    endtask

    function automatic object_cols_t model_cols();
        object_cols_t c;
        c.coin = m_col[0];
        c.ghost = m_col[1];
        c.life = m_col[2];
        c.cliff = m_col[3];
        c.coin_row = 5'(23 + int'(m_pick));  // coin rows 23..26
        return c;
    endfunction

    task automatic compare_all();
        check_score(score, m_score);
        check_offset(bg_x_offset, m_over ? offset_t'(0) : m_offset);
        check_flags("dead", dead, m_dead);
        check_flags("on_ground", on_ground, m_ground);
        check_bit("game_over", game_over, m_over);
        check_cols(cols, model_cols());
        check_write(tile_wr, m_wr);
    endtask

    // player span px..px+16 against one tile column
    function automatic logic touches(input int px, input int col, input logic upper_incl);
        int left;
        left = col * tile_px;
        if (upper_incl) begin
            return (px + tile_px >= left) && (px <= left + tile_px);
        end
        return (px + tile_px >= left) && (px < left + tile_px);
    endfunction

    // two tiles above the row down to the row below it
    function automatic logic in_band(input int py, input int row);
        return (py >= row * tile_px - 2 * tile_px) && (py <= (row + 1) * tile_px);
    endfunction

    function automatic tile_write_t expected_tile(input object_cols_t c, input int slot,
                                                  input logic coin_gone, input logic life_gone,
                                                  input logic [1:0] frame);
        tile_write_t w;
        int gx;
        int gy;
        int rel;
        w = '0;
        w.strobe = 1'b1;
        w.attr.enable = 1'b1;
        if (slot < 3 * tile_cols) begin
            gx = slot % tile_cols;
            gy = slot / tile_cols;
            rel = gx - int'(c.cliff);
            w.addr = tile_addr_t'(gx + (ground_row + gy) * tile_cols);
            if (rel == -3 || rel == -2) begin
                w.strobe = 1'b0;  // open gap
            end else if (rel == -4 || rel == -1) begin
                w.attr.flip = (rel == -1) ? 2'b01 : 2'b00;
                w.attr.sheet_row = (gy == 0) ? 3'd6 : 3'd7;
                w.attr.sheet_col = (gy == 0) ? 3'd1 : 3'd0;
            end else begin
                w.attr.sheet_row = 3'd6;
                w.attr.sheet_col = (gy == 0) ? 3'd0 : 3'd3;
            end
        end else if (slot == 3 * tile_cols) begin
            w.addr = tile_addr_t'(int'(c.coin) + int'(c.coin_row) * tile_cols);
            w.attr.enable = !coin_gone;
            w.attr.sheet_row = 3'd7;
            w.attr.sheet_col = 3'(int'(frame) + 4);
        end else if (slot == 3 * tile_cols + 1) begin
            w.addr = tile_addr_t'(int'(c.ghost) + ghost_row * tile_cols);
            w.attr.flip = 2'b01;
            w.attr.sheet_row = 3'd6;
            w.attr.sheet_col = 3'd5;
        end else begin
            w.addr = tile_addr_t'(int'(c.life) + life_row * tile_cols);
            w.attr.enable = !life_gone;
            w.attr.sheet_row = 3'd5;
            w.attr.sheet_col = 3'd5;
        end
        return w;
    endfunction

    task automatic reset_model();
        m_cnt = '0;
        m_delay = delay_max;
        m_offset = '0;
        m_score = '0;
        m_dead = '0;
        m_ground = '1;
        m_over = 1'b0;
        m_coin_eaten = 1'b0;
        m_life_eaten = 1'b0;
        m_slot = 0;
        m_anim = 0;
        m_wr = '0;
        for (int k = 0; k < 4; k++) begin
            m_lfsr[k] = track_seed[k];
            m_col[k] = track_start[k];
        end
        m_pick = '0;
    endtask

    // advance the model over the coming clock edge
    task automatic step_model();
        object_cols_t c;
        logic tick;
        logic coarse;
        logic all_dead;
        logic coin_back;
        logic life_back;
        logic revive;
        logic [player_count-1:0] coin_hit;
        logic [player_count-1:0] kill;
        logic [player_count-1:0] life_hit;
        logic [player_count-1:0] gap;
        int px;
        int py;
        int low;
        c = model_cols();
        if (!game_on) begin
            m_wr.strobe = 1'b0;
            return;
        end
        all_dead = &m_dead;
        tick = (m_cnt == m_delay);
        coarse = tick && (m_offset == 4'd15);
        coin_back = coarse && (c.coin == 8'd0);
        life_back = coarse && (c.life == 8'd0);
        for (int i = 0; i < player_count; i++) begin
            px = int'(players[i].x) + int'(m_offset);  // world x
            py = int'(players[i].y);
            coin_hit[i] = touches(px, int'(c.coin), 1'b0)
                && (py >= (int'(c.coin_row) - 1) * tile_px)
                && (py <= (int'(c.coin_row) + 1) * tile_px);
            kill[i] = (py >= fall_y) || (touches(px, int'(c.ghost), 1'b1) && in_band(py, ghost_row));
            life_hit[i] = touches(px, int'(c.life), 1'b1) && in_band(py, life_row);
            gap[i] = (px >= (int'(c.cliff) - 4) * tile_px) && (px <= (int'(c.cliff) - 2) * tile_px);
        end

        for (int k = 0; k < 4; k++) begin
            if (coarse && m_col[k] == 8'd0) begin
                m_col[k] = col_t'(int'(track_base[k]) + int'(m_lfsr[k]) % int'(track_span[k]));
                if (k == 0) begin
                    m_pick = 2'(int'(m_lfsr[k]) % 4);
                end
            end else if (coarse) begin
                m_col[k] = m_col[k] - 8'd1;
            end
            m_lfsr[k] = {m_lfsr[k][6:0], m_lfsr[k][7] ^ m_lfsr[k][5]};
        end

        m_wr = expected_tile(c, m_slot, m_coin_eaten, m_life_eaten, 2'((m_anim / 256) % 4));
        m_slot = (m_slot + 1) % (3 * tile_cols + 3);
        m_anim = m_anim + 1;

        if (coarse && !m_over && (m_delay > delay_min) && ((int'(m_score) + 1) % 10 == 0)) begin
            m_delay = m_delay - delay_step;  // speed-up milestone
        end
        if (tick) begin
            m_cnt = '0;
            m_offset = m_offset + 4'd1;
        end else begin
            m_cnt = m_cnt + 16'd1;
        end

        if (coin_back) begin
            m_coin_eaten = 1'b0;
        end else if ((|coin_hit) && !m_coin_eaten && !m_over) begin
            m_coin_eaten = 1'b1;
            m_score = m_score + 16'd1;
        end

        revive = !life_back && (|life_hit) && !m_life_eaten;
        if (life_back) begin
            m_life_eaten = 1'b0;
        end else if (revive) begin
            m_life_eaten = 1'b1;
        end
        low = -1;
        for (int i = player_count - 1; i >= 0; i--) begin
            if (m_dead[i]) begin
                low = i;
            end
        end
        if (revive && low >= 0) begin
            m_dead[low] = 1'b0;
        end
        m_dead = m_dead | kill;  // a new death beats a revival
        m_ground = ~gap;
        m_over = m_over || all_dead;
    endtask

    function automatic logic [9:0] aim_x(input col_t col, input int jitter);
        return 10'(int'(col) * tile_px - int'(m_offset) + jitter);
    endfunction

    function automatic logic near(input col_t a, input col_t b);
        return (int'(a) - int'(b) <= 2) && (int'(b) - int'(a) <= 2);
    endfunction

    // phase 0 idle, 1 coins only, 2 sparse deaths and revivals, 3 everybody falls
    task automatic drive_inputs(input int phase);
        object_cols_t c;
        int jitter;
        int kind;
        int rare;
        c = model_cols();
        game_on = (phase == 0) ? 1'b0 : (random_bits(5) != 0);
        for (int i = 0; i < player_count; i++) begin
            players[i].x = 10'(random_bits(10));
            players[i].y = 10'(random_bits(8));  // well above the ghost band
            jitter = random_bits(3);
            kind = random_bits(2);
            rare = random_bits(14);
            if (phase == 3) begin
                players[i].y = 10'(fall_y + random_bits(5));
            end else if (phase == 2 && rare == 0) begin
                if (kind[0]) begin
                    players[i].y = 10'(fall_y);
                end else begin
                    players[i].x = aim_x(c.ghost, jitter);
                    players[i].y = 10'(ghost_row * tile_px);
                end
            end else if (phase == 2 && kind == 1 && m_dead != '0) begin
                players[i].x = aim_x(c.life, jitter);
                players[i].y = 10'(life_row * tile_px - tile_px);
            end else if (phase >= 1 && kind == 0 && !near(c.coin, c.ghost)) begin
                players[i].x = aim_x(c.coin, jitter);
                players[i].y = 10'((int'(c.coin_row) - 1) * tile_px + jitter);
            end
        end
    endtask

    task automatic run_cycles(input int n, input int phase);
        repeat (n) begin
            @(negedge clk);
            compare_all();
            drive_inputs(phase);
            step_model();
        end
    endtask

    initial begin
        #(watchdog_ns);
        abort_run("watchdog expired before the test sequence finished");
    end

    initial begin
        rng = 32'd94297;
        reset = 1'b1;
        game_on = 1'b0;
        players = '0;
        reset_model();
        repeat (2) @(negedge clk);
        compare_all();  // values right after reset
        reset = 1'b0;
        step_model();

        run_cycles(idle_cycles, 0);
        run_cycles(coin_cycles, 1);
        if (score == '0) begin
            abort_run("no coin was collected during the coin phase");
        end
        run_cycles(mixed_cycles, 2);
        run_cycles(fall_cycles, 3);
        if (!game_over) begin
            abort_run("game_over never rose after all players fell");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: verif/game_engine_sva.sv
`timescale 1ns/1ps
`default_nettype none

module game_engine_sva (
    input logic                     clk,
    input logic                     reset,
    input logic                     scroll_tick,
    input logic                     coarse_tick,
    input logic                     game_over,
    input play_pkg::score_t         score,
    input display_pkg::tile_write_t tile_wr
);
    import display_pkg::*;

    wr_addr_in_map: assert property (@(posedge clk) disable iff (reset)
        tile_wr.strobe |-> (int'(tile_wr.addr) < tile_cols * tile_rows))
        else $error("tile write address outside the map");

    scroll_tick_pulse: assert property (@(posedge clk) disable iff (reset)
        scroll_tick |=> !scroll_tick)
        else $error("scroll_tick high for more than one cycle");

    coarse_tick_pulse: assert property (@(posedge clk) disable iff (reset)
        coarse_tick |=> !coarse_tick)
        else $error("coarse_tick high for more than one cycle");

    // sticky until reset
    game_over_holds: assert property (@(posedge clk) disable iff (reset)
        !$fell(game_over))
        else $error("game_over dropped without reset");

    score_step: assert property (@(posedge clk) disable iff (reset)
        (score == $past(score)) || (score == $past(score) + 16'd1))
        else $error("score moved by more than one in a cycle");

endmodule

bind game_engine game_engine_sva u_sva (
    .clk(clk), .reset(reset), .scroll_tick(scroll_tick), .coarse_tick(coarse_tick),
    .game_over(game_over), .score(score), .tile_wr(tile_wr)
);

`default_nettype wire

// File: logic/game_engine.sv
`timescale 1ns/1ps
`default_nettype none

module game_engine (
    input  logic                                               clk,
    input  logic                                               reset,
    input  logic                                               game_on,
    input  play_pkg::player_pos_t [play_pkg::player_count-1:0] players,
    output play_pkg::offset_t                                  bg_x_offset,
    output play_pkg::object_cols_t                             cols,
    output play_pkg::score_t                                   score,
    output logic [play_pkg::player_count-1:0]                  dead,
    output logic [play_pkg::player_count-1:0]                  on_ground,
    output logic                                               game_over,
    output display_pkg::tile_write_t                           tile_wr
);
    import play_pkg::*;
    import display_pkg::*;

    offset_t    offset;
    logic       scroll_tick;
    logic       coarse_tick;
    col_t       coin_col;
    col_t       ghost_col;
    col_t       life_col;
    col_t       cliff_col;
    logic [1:0] coin_row_pick;
    logic       coin_respawn;
    logic       life_respawn;
    logic       coin_eaten;
    logic       life_eaten;
    logic [9:0] anim_cnt;   // coin frame advances every 256 clocks

    assign cols = '{coin: coin_col, ghost: ghost_col, life: life_col, cliff: cliff_col,
                    coin_row: coin_row_base + 5'(coin_row_pick)};

    assign bg_x_offset = game_over ? '0 : offset;  // freeze the picture when over

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            anim_cnt <= '0;
        end else if (game_on) begin
            anim_cnt <= anim_cnt + 1'b1;
        end
    end

    scroll_timer u_scroll (
        .clk(clk), .reset(reset), .game_on(game_on), .game_over(game_over), .score(score),
        .offset(offset), .scroll_tick(scroll_tick), .coarse_tick(coarse_tick)
    );

    object_track #(.seed(8'b01101001), .respawn_base(34), .respawn_span(6), .reset_col(8'd38))
    u_coin (
        .clk(clk), .reset(reset), .game_on(game_on), .coarse_tick(coarse_tick),
        .col(coin_col), .row_pick(coin_row_pick), .respawn(coin_respawn)
    );

    object_track #(.seed(8'b10100110), .respawn_base(50), .respawn_span(5), .reset_col(8'd37))
    u_ghost (
        .clk(clk), .reset(reset), .game_on(game_on), .coarse_tick(coarse_tick),
        .col(ghost_col), .row_pick(), .respawn()
    );

    object_track #(.seed(8'b00101110), .respawn_base(90), .respawn_span(5), .reset_col(8'd37))
    u_life (
        .clk(clk), .reset(reset), .game_on(game_on), .coarse_tick(coarse_tick),
        .col(life_col), .row_pick(), .respawn(life_respawn)
    );

    object_track #(.seed(8'b10110101), .respawn_base(50), .respawn_span(101), .reset_col(8'd20))
    u_cliff (
        .clk(clk), .reset(reset), .game_on(game_on), .coarse_tick(coarse_tick),
        .col(cliff_col), .row_pick(), .respawn()
    );

    player_referee u_referee (
        .clk(clk), .reset(reset), .game_on(game_on), .players(players), .cols(cols),
        .offset(offset), .coin_respawn(coin_respawn), .life_respawn(life_respawn),
        .score(score), .dead(dead), .on_ground(on_ground), .game_over(game_over),
        .coin_eaten(coin_eaten), .life_eaten(life_eaten)
    );

    tile_writer u_tiles (
        .clk(clk), .reset(reset), .game_on(game_on), .cols(cols),
        .coin_eaten(coin_eaten), .life_eaten(life_eaten), .coin_frame(anim_cnt[9:8]),
        .wr(tile_wr)
    );

endmodule

`default_nettype wire

// File: logic/tile_writer.sv
`timescale 1ns/1ps
`default_nettype none

module tile_writer (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     game_on,
    input  play_pkg::object_cols_t   cols,
    input  logic                     coin_eaten,
    input  logic                     life_eaten,
    input  logic [1:0]               coin_frame,
    output display_pkg::tile_write_t wr
);
    import display_pkg::*;

    localparam int ground_slots = 3 * tile_cols;     // 120
    localparam int coin_slot    = ground_slots;
    localparam int ghost_slot   = ground_slots + 1;
    localparam int life_slot    = ground_slots + 2;  // last slot of a pass

    logic [6:0]  slot;
    logic [5:0]  gx;   // ground column
    logic [1:0]  gy;   // ground row within the three
    tile_write_t next_wr;

    always_comb begin
        int  rel;
        logic top;
        rel = int'(gx) - int'(cols.cliff);
        top = (gy == 2'd0);

        next_wr = '0;
        next_wr.strobe = 1'b1;
        next_wr.attr.enable = 1'b1;

        if (slot < ground_slots) begin
            next_wr.addr = tile_addr_t'(int'(gx) + (ground_row + int'(gy)) * tile_cols);
            if (rel == -4 || rel == -1) begin
                // cliff edges, right one mirrored
                next_wr.attr.flip      = (rel == -1) ? 2'b01 : 2'b00;
                next_wr.attr.sheet_row = top ? 3'd6 : 3'd7;
                next_wr.attr.sheet_col = top ? 3'd1 : 3'd0;
            end else if (rel == -3 || rel == -2) begin
                next_wr.strobe = 1'b0;  // the gap itself
            end else begin
                next_wr.attr.sheet_row = 3'd6;
                next_wr.attr.sheet_col = top ? 3'd0 : 3'd3;
            end
        end else if (slot == coin_slot) begin
            next_wr.addr = tile_addr_t'(int'(cols.coin) + int'(cols.coin_row) * tile_cols);
            next_wr.attr.enable    = ~coin_eaten;
            next_wr.attr.sheet_row = 3'd7;
            next_wr.attr.sheet_col = 3'(coin_frame) + 3'd4;  // spin frames 4..7
        end else if (slot == ghost_slot) begin
            next_wr.addr = tile_addr_t'(int'(cols.ghost) + ghost_row * tile_cols);
            next_wr.attr.flip      = 2'b01;
            next_wr.attr.sheet_row = 3'd6;
            next_wr.attr.sheet_col = 3'd5;
        end else begin
            next_wr.addr = tile_addr_t'(int'(cols.life) + life_row * tile_cols);
            next_wr.attr.enable    = ~life_eaten;
            next_wr.attr.sheet_row = 3'd5;
            next_wr.attr.sheet_col = 3'd5;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            slot <= '0;
            gx   <= '0;
            gy   <= '0;
            wr   <= '0;
        end else if (!game_on) begin
            wr.strobe <= 1'b0;
        end else begin
            wr <= next_wr;
            if (slot == life_slot) begin
                slot <= '0;  // next pass starts straight away
                gx   <= '0;
                gy   <= '0;
            end else begin
                slot <= slot + 1'b1;
                if (gx == tile_cols - 1) begin
                    gx <= '0;
                    gy <= gy + 1'b1;
                end else begin
                    gx <= gx + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/player_referee.sv
`timescale 1ns/1ps
`default_nettype none

module player_referee (
    input  logic                                                 clk,
    input  logic                                                 reset,
    input  logic                                                 game_on,
    input  play_pkg::player_pos_t [play_pkg::player_count-1:0]   players,
    input  play_pkg::object_cols_t                               cols,
    input  play_pkg::offset_t                                    offset,
    input  logic                                                 coin_respawn,
    input  logic                                                 life_respawn,
    output play_pkg::score_t                                     score,
    output logic [play_pkg::player_count-1:0]                    dead,
    output logic [play_pkg::player_count-1:0]                    on_ground,
    output logic                                                 game_over,
    output logic                                                 coin_eaten,
    output logic                                                 life_eaten
);
    import play_pkg::*;
    import display_pkg::*;

    logic [player_count-1:0] coin_hit;
    logic [player_count-1:0] kill;
    logic [player_count-1:0] life_hit;
    logic [player_count-1:0] over_gap;
    logic [player_count-1:0] revive_mask;
    logic                    revive;

    // player x span px..px+16 against one tile column
    function automatic logic x_overlap(input int px, input int col, input logic upper_incl);
        int left_px;
        int right_px;
        left_px  = col * tile_px;
        right_px = (col + 1) * tile_px;
        if (px + tile_px < left_px) begin
            return 1'b0;
        end
        return upper_incl ? (px <= right_px) : (px < right_px);
    endfunction

    always_comb begin
        int px;
        int py;
        for (int i = 0; i < player_count; i++) begin
            px = int'(players[i].x) + int'(offset);  // screen x to world x
            py = int'(players[i].y);

            coin_hit[i] = x_overlap(px, int'(cols.coin), 1'b0)
                && (py >= (int'(cols.coin_row) - 1) * tile_px)
                && (py <= (int'(cols.coin_row) + 1) * tile_px);

            kill[i] = (py >= fall_y)
                || (x_overlap(px, int'(cols.ghost), 1'b1)
                    && (py + 2 * tile_px >= ghost_row * tile_px)
                    && (py <= (ghost_row + 1) * tile_px));

            life_hit[i] = x_overlap(px, int'(cols.life), 1'b1)
                && (py + 2 * tile_px >= life_row * tile_px)
                && (py <= (life_row + 1) * tile_px);

            // the two open tiles of the cliff, with some slack on the left
            over_gap[i] = (px >= (int'(cols.cliff) - 4) * tile_px)
                && (px <= (int'(cols.cliff) - 2) * tile_px);
        end
    end

    assign revive_mask = dead & (~dead + 1'b1);  // lowest dead player
    assign revive      = !life_respawn && (|life_hit) && !life_eaten;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            score      <= '0;
            dead       <= '0;
            on_ground  <= '1;
            game_over  <= 1'b0;
            coin_eaten <= 1'b0;
            life_eaten <= 1'b0;
        end else if (game_on) begin
            on_ground <= ~over_gap;
            game_over <= game_over || (&dead);  // sticky until reset

            if (coin_respawn) begin
                coin_eaten <= 1'b0;
            end else if ((|coin_hit) && !coin_eaten && !game_over) begin
                coin_eaten <= 1'b1;
                score      <= score + 1'b1;  // one point per coin however many touch it
            end

            if (life_respawn) begin
                life_eaten <= 1'b0;
            end else if (revive) begin
                life_eaten <= 1'b1;
            end

            // a fresh death wins over a revival in the same cycle
            dead <= (dead & ~(revive ? revive_mask : '0)) | kill;
        end
    end

endmodule

`default_nettype wire

// File: logic/object_track.sv
`timescale 1ns/1ps
`default_nettype none

module object_track #(
    parameter logic [7:0]     seed         = 8'hb5,
    parameter int             respawn_base = 50,
    parameter int             respawn_span = 101,
    parameter play_pkg::col_t reset_col    = 8'd20
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           game_on,
    input  logic           coarse_tick,
    output play_pkg::col_t col,
    output logic [1:0]     row_pick,
    output logic           respawn
);
    import play_pkg::*;

    logic [7:0] lfsr;
    col_t       spawn_col;

    assign respawn   = game_on && coarse_tick && (col == '0);
    assign spawn_col = col_t'(respawn_base + int'(lfsr) % respawn_span);

    // free running while the game runs, taps 7 and 5
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lfsr <= seed;
        end else if (game_on) begin
            lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5]};
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            col      <= reset_col;
            row_pick <= '0;
        end else if (respawn) begin
            col      <= spawn_col;  // back in off the right edge
            row_pick <= lfsr[1:0];  // lfsr mod 4
        end else if (game_on && coarse_tick) begin
            col <= col - 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: logic/scroll_timer.sv
`timescale 1ns/1ps
`default_nettype none

module scroll_timer (
    input  logic              clk,
    input  logic              reset,
    input  logic              game_on,
    input  logic              game_over,
    input  play_pkg::score_t  score,
    output play_pkg::offset_t offset,
    output logic              scroll_tick,
    output logic              coarse_tick
);
    import play_pkg::*;

    delay_t      cnt;
    delay_t      delay;         // current scroll period minus one
    logic [16:0] score_inc;
    logic        milestone;

    assign scroll_tick = game_on && (cnt == delay);
    assign coarse_tick = scroll_tick && (offset == 4'd15);  // last fine step of a tile

    // speed up when the next point lands on a multiple of ten
    assign score_inc = {1'b0, score} + 17'd1;
    assign milestone = (score_inc % 17'd10) == 17'd0;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cnt    <= '0;
            delay  <= delay_max;
            offset <= '0;
        end else if (game_on) begin
            if (scroll_tick) begin
                cnt    <= '0;
                offset <= offset + 1'b1;  // wraps at 16
            end else begin
                cnt <= cnt + 1'b1;
            end

            if (coarse_tick && !game_over && (delay > delay_min) && milestone) begin
                delay <= delay - delay_step;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/play_pkg.sv
`default_nettype none

package play_pkg;

    // scroll delay in clocks, short values for simulation
    localparam logic [15:0] delay_max  = 16'd64;
    localparam logic [15:0] delay_min  = 16'd16;
    localparam logic [15:0] delay_step = 16'd8;

    typedef logic [15:0] delay_t;
    typedef logic [3:0]  offset_t;   // fine scroll within one tile

    localparam int player_count = 3;
    localparam int fall_y       = 480;  // bottom of the screen

    // pixel position of one player
    typedef struct packed {
        logic [9:0] x;
        logic [9:0] y;
    } player_pos_t;

    typedef logic [7:0] col_t;

    // tile columns of everything that scrolls
    typedef struct packed {
        col_t       coin;
        col_t       ghost;
        col_t       life;
        col_t       cliff;
        logic [4:0] coin_row;
    } object_cols_t;

    typedef logic [15:0] score_t;

endpackage

`default_nettype wire

// File: logic/display_pkg.sv
`default_nettype none

package display_pkg;

    // tile map geometry, 640x480 screen in 16 px tiles
    localparam int tile_cols = 40;
    localparam int tile_rows = 30;
    localparam int tile_px   = 16;

    localparam int ground_row = tile_rows - 3;  // rows 27..29 are ground
    localparam int ghost_row  = 26;
    localparam int life_row   = 23;

    localparam logic [4:0] coin_row_base = 5'd23;  // coin rows 23..26

    // col + row * tile_cols
    typedef logic [15:0] tile_addr_t;

    // tile RAM word
    typedef struct packed {
        logic       enable;
        logic [1:0] flip;       // bit 0 is horizontal
        logic [2:0] sheet_row;
        logic [2:0] sheet_col;
    } tile_attr_t;

    typedef struct packed {
        logic       strobe;
        tile_addr_t addr;
        tile_attr_t attr;
    } tile_write_t;

endpackage

`default_nettype wire
